// ==== rtl/mini_mcu_pkg.sv ====
// mini_mcu shared definitions
// Bus widths, address map, register offsets and interrupt bit positions
package mini_mcu_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [7:0]  reg_off_t;
  typedef logic [7:0]  gpio_t;
  typedef logic [15:0] intr_t;

  // RAM geometry
  localparam int unsigned NUM_BANKS    = 2;
  localparam int unsigned BANK_WORDS   = 256;
  localparam int unsigned WORD_LSB     = 2;
  localparam int unsigned WORD_IDX_W   = $clog2(BANK_WORDS);
  localparam int unsigned BANK_SEL_LSB = WORD_LSB + WORD_IDX_W;
  localparam int unsigned BANK_SEL_W   = $clog2(NUM_BANKS);

  typedef logic [WORD_IDX_W-1:0] word_idx_t;

  // Address map
  localparam addr_t RAM_BASE       = 32'h0000_0000;
  localparam addr_t RAM_SIZE       = 32'h0000_0800;
  localparam addr_t PERIPH_BASE    = 32'h0001_0000;
  localparam addr_t PERIPH_SIZE    = 32'h0000_0100;
  localparam data_t UNMAPPED_RDATA = 32'hBADC_AB1E;

  // Peripheral register offsets
  localparam reg_off_t REG_DMA_SRC     = 8'h00;
  localparam reg_off_t REG_DMA_DST     = 8'h04;
  localparam reg_off_t REG_DMA_LEN     = 8'h08;
  localparam reg_off_t REG_DMA_STATUS  = 8'h0C;
  localparam reg_off_t REG_GPIO_OUT    = 8'h10;
  localparam reg_off_t REG_GPIO_OE     = 8'h14;
  localparam reg_off_t REG_GPIO_IN     = 8'h18;
  localparam reg_off_t REG_INTR_STATUS = 8'h1C;
  localparam reg_off_t REG_INTR_ENABLE = 8'h20;

  // GPIO pin i maps to interrupt bit INTR_GPIO_LSB + i
  localparam int unsigned INTR_DMA_DONE_BIT = 0;
  localparam int unsigned INTR_GPIO_LSB     = 8;

  typedef enum logic [2:0] {
    DMA_IDLE       = 3'd0,
    DMA_READ       = 3'd1,
    DMA_READ_WAIT  = 3'd2,
    DMA_WRITE      = 3'd3,
    DMA_WRITE_WAIT = 3'd4
  } dma_state_e;

endpackage

// ==== rtl/bus_arbiter.sv ====
// System bus arbiter
// Round-robin between host and DMA with RAM, peripheral and unmapped decode
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     host_req_i,
  input  logic                     host_we_i,
  input  mini_mcu_pkg::addr_t      host_addr_i,
  input  mini_mcu_pkg::data_t      host_wdata_i,
  output logic                     host_gnt_o,
  output logic                     host_rvalid_o,
  output mini_mcu_pkg::data_t      host_rdata_o,
  input  logic                     dma_req_i,
  input  logic                     dma_we_i,
  input  mini_mcu_pkg::addr_t      dma_addr_i,
  input  mini_mcu_pkg::data_t      dma_wdata_i,
  output logic                     dma_gnt_o,
  output logic                     dma_rvalid_o,
  output mini_mcu_pkg::data_t      dma_rdata_o,
  output logic                     ram_req_o,
  output logic                     ram_we_o,
  output mini_mcu_pkg::addr_t      ram_addr_o,
  output mini_mcu_pkg::data_t      ram_wdata_o,
  input  mini_mcu_pkg::data_t      ram_rdata_i,
  output logic                     periph_req_o,
  output logic                     periph_we_o,
  output mini_mcu_pkg::reg_off_t   periph_off_o,
  output mini_mcu_pkg::data_t      periph_wdata_o,
  input  mini_mcu_pkg::data_t      periph_rdata_i
);

  logic                last_dma_q;
  logic                any_gnt;
  logic                sel_we;
  mini_mcu_pkg::addr_t sel_addr;
  mini_mcu_pkg::data_t sel_wdata;
  mini_mcu_pkg::addr_t ram_rel;
  mini_mcu_pkg::addr_t periph_rel;
  logic                ram_hit;
  logic                periph_hit;
  logic                rsp_valid_q;
  logic                rsp_host_q;
  logic                rsp_ram_q;
  logic                rsp_periph_q;
  mini_mcu_pkg::data_t rsp_rdata;

  // Host wins unless the DMA is waiting and the host had the last grant
  assign host_gnt_o = host_req_i & (~dma_req_i | last_dma_q);
  assign dma_gnt_o  = dma_req_i & ~host_gnt_o;
  assign any_gnt    = host_gnt_o | dma_gnt_o;

  assign sel_we    = host_gnt_o ? host_we_i    : dma_we_i;
  assign sel_addr  = host_gnt_o ? host_addr_i  : dma_addr_i;
  assign sel_wdata = host_gnt_o ? host_wdata_i : dma_wdata_i;

  assign ram_rel    = sel_addr - mini_mcu_pkg::RAM_BASE;
  assign periph_rel = sel_addr - mini_mcu_pkg::PERIPH_BASE;
  assign ram_hit    = ram_rel < mini_mcu_pkg::RAM_SIZE;
  assign periph_hit = periph_rel < mini_mcu_pkg::PERIPH_SIZE;

  assign ram_req_o   = any_gnt & ram_hit;
  assign ram_we_o    = sel_we;
  assign ram_addr_o  = ram_rel;
  assign ram_wdata_o = sel_wdata;

  assign periph_req_o   = any_gnt & periph_hit;
  assign periph_we_o    = sel_we;
  assign periph_off_o   = mini_mcu_pkg::reg_off_t'(periph_rel);
  assign periph_wdata_o = sel_wdata;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_dma_q   <= 1'b1;
      rsp_valid_q  <= 1'b0;
      rsp_host_q   <= 1'b0;
      rsp_ram_q    <= 1'b0;
      rsp_periph_q <= 1'b0;
    end else begin
      rsp_valid_q <= any_gnt;
      if (any_gnt) begin
        last_dma_q   <= dma_gnt_o;
        rsp_host_q   <= host_gnt_o;
        rsp_ram_q    <= ram_hit;
        rsp_periph_q <= periph_hit;
      end
    end
  end

  // Response follows the registered target and unmapped reads get a marker
  assign rsp_rdata = rsp_ram_q    ? ram_rdata_i    :
                     rsp_periph_q ? periph_rdata_i :
                                    mini_mcu_pkg::UNMAPPED_RDATA;

  assign host_rvalid_o = rsp_valid_q & rsp_host_q;
  assign dma_rvalid_o  = rsp_valid_q & ~rsp_host_q;
  assign host_rdata_o  = rsp_rdata;
  assign dma_rdata_o   = rsp_rdata;

endmodule

// ==== rtl/ram_bank_array.sv ====
// Banked word RAM
// Single port, one bank per access, read data on the next cycle
`timescale 1ns/1ps

module ram_bank_array (
  input  logic                clk_i,
  input  logic                req_i,
  input  logic                we_i,
  input  mini_mcu_pkg::addr_t addr_i,
  input  mini_mcu_pkg::data_t wdata_i,
  output mini_mcu_pkg::data_t rdata_o
);

  logic [mini_mcu_pkg::BANK_SEL_W-1:0] bank_sel;
  logic [mini_mcu_pkg::BANK_SEL_W-1:0] bank_q;
  mini_mcu_pkg::word_idx_t             word_idx;
  mini_mcu_pkg::data_t                 bank_rdata [mini_mcu_pkg::NUM_BANKS];

  assign word_idx = addr_i[mini_mcu_pkg::WORD_LSB +: mini_mcu_pkg::WORD_IDX_W];
  assign bank_sel = addr_i[mini_mcu_pkg::BANK_SEL_LSB +: mini_mcu_pkg::BANK_SEL_W];

  for (genvar b = 0; b < mini_mcu_pkg::NUM_BANKS; b++) begin : g_bank
    mini_mcu_pkg::data_t mem [mini_mcu_pkg::BANK_WORDS];
    mini_mcu_pkg::data_t rdata_q;
    logic                bank_req;

    assign bank_req = req_i && (bank_sel == b);

    always_ff @(posedge clk_i) begin
      if (bank_req) begin
        if (we_i) begin
          mem[word_idx] <= wdata_i;
        end else begin
          rdata_q <= mem[word_idx];
        end
      end
    end

    assign bank_rdata[b] = rdata_q;
  end

  // Remember which bank answers the pending read
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      bank_q <= bank_sel;
    end
  end

  assign rdata_o = bank_rdata[bank_q];

endmodule

// ==== rtl/dma_engine.sv ====
// Single-channel DMA engine
// Copies len words from src to dst with one read and one write per word
`timescale 1ns/1ps

module dma_engine (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                start_i,
  input  mini_mcu_pkg::addr_t src_i,
  input  mini_mcu_pkg::addr_t dst_i,
  input  mini_mcu_pkg::data_t len_i,
  output logic                busy_o,
  output logic                done_o,
  output logic                bus_req_o,
  output logic                bus_we_o,
  output mini_mcu_pkg::addr_t bus_addr_o,
  output mini_mcu_pkg::data_t bus_wdata_o,
  input  logic                bus_gnt_i,
  input  logic                bus_rvalid_i,
  input  mini_mcu_pkg::data_t bus_rdata_i
);

  mini_mcu_pkg::dma_state_e state_q;
  mini_mcu_pkg::data_t      count_q;
  mini_mcu_pkg::addr_t      src_q;
  mini_mcu_pkg::addr_t      dst_q;
  mini_mcu_pkg::data_t      word_q;
  logic                     last_word;

  assign last_word = (count_q == mini_mcu_pkg::data_t'(1));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= mini_mcu_pkg::DMA_IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        mini_mcu_pkg::DMA_IDLE: begin
          if (start_i && len_i != '0) begin
            count_q <= len_i;
            state_q <= mini_mcu_pkg::DMA_READ;
          end
        end
        mini_mcu_pkg::DMA_READ: begin
          if (bus_gnt_i) begin
            state_q <= mini_mcu_pkg::DMA_READ_WAIT;
          end
        end
        mini_mcu_pkg::DMA_READ_WAIT: begin
          if (bus_rvalid_i) begin
            state_q <= mini_mcu_pkg::DMA_WRITE;
          end
        end
        mini_mcu_pkg::DMA_WRITE: begin
          if (bus_gnt_i) begin
            state_q <= mini_mcu_pkg::DMA_WRITE_WAIT;
          end
        end
        mini_mcu_pkg::DMA_WRITE_WAIT: begin
          if (bus_rvalid_i) begin
            count_q <= count_q - 1'b1;
            state_q <= last_word ? mini_mcu_pkg::DMA_IDLE : mini_mcu_pkg::DMA_READ;
          end
        end
        default: state_q <= mini_mcu_pkg::DMA_IDLE;
      endcase
    end
  end

  // Pointers and the word in transit
  always_ff @(posedge clk_i) begin
    if (state_q == mini_mcu_pkg::DMA_IDLE && start_i) begin
      src_q <= src_i;
      dst_q <= dst_i;
    end else if (state_q == mini_mcu_pkg::DMA_WRITE_WAIT && bus_rvalid_i) begin
      src_q <= src_q + 32'd4;
      dst_q <= dst_q + 32'd4;
    end
    if (state_q == mini_mcu_pkg::DMA_READ_WAIT && bus_rvalid_i) begin
      word_q <= bus_rdata_i;
    end
  end

  // Busy already in the start cycle so a second start is refused
  assign busy_o = (state_q != mini_mcu_pkg::DMA_IDLE) | start_i;
  assign done_o = (state_q == mini_mcu_pkg::DMA_WRITE_WAIT) & bus_rvalid_i & last_word;

  assign bus_req_o   = (state_q == mini_mcu_pkg::DMA_READ) |
                       (state_q == mini_mcu_pkg::DMA_WRITE);
  assign bus_we_o    = (state_q == mini_mcu_pkg::DMA_WRITE);
  assign bus_addr_o  = bus_we_o ? dst_q : src_q;
  assign bus_wdata_o = word_q;

endmodule

// ==== rtl/ao_peripherals.sv ====
// Always-on peripheral registers
// DMA channel setup, GPIO bank with edge interrupts, interrupt status/enable
`timescale 1ns/1ps

module ao_peripherals (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  mini_mcu_pkg::reg_off_t off_i,
  input  mini_mcu_pkg::data_t    wdata_i,
  output mini_mcu_pkg::data_t    rdata_o,
  output logic                   dma_start_o,
  output mini_mcu_pkg::addr_t    dma_src_o,
  output mini_mcu_pkg::addr_t    dma_dst_o,
  output mini_mcu_pkg::data_t    dma_len_o,
  input  logic                   dma_busy_i,
  input  logic                   dma_done_i,
  input  mini_mcu_pkg::gpio_t    gpio_i,
  output mini_mcu_pkg::gpio_t    gpio_o,
  output mini_mcu_pkg::gpio_t    gpio_oe_o,
  output logic                   intr_o
);

  logic                wr;
  logic                len_wr;
  logic                start_q;
  mini_mcu_pkg::addr_t src_q;
  mini_mcu_pkg::addr_t dst_q;
  mini_mcu_pkg::data_t len_q;
  mini_mcu_pkg::gpio_t out_q;
  mini_mcu_pkg::gpio_t oe_q;
  mini_mcu_pkg::gpio_t sync1_q;
  mini_mcu_pkg::gpio_t sync2_q;
  mini_mcu_pkg::gpio_t prev_q;
  mini_mcu_pkg::gpio_t rise;
  mini_mcu_pkg::intr_t status_q;
  mini_mcu_pkg::intr_t enable_q;
  mini_mcu_pkg::intr_t set_vec;
  mini_mcu_pkg::intr_t clr_vec;
  mini_mcu_pkg::data_t rdata_q;

  assign wr     = req_i & we_i;
  // A length write only counts while the channel is idle
  assign len_wr = wr && (off_i == mini_mcu_pkg::REG_DMA_LEN) && (wdata_i != '0) && !dma_busy_i;
  assign rise   = sync2_q & ~prev_q;

  always_comb begin
    set_vec = '0;
    set_vec[mini_mcu_pkg::INTR_DMA_DONE_BIT] = dma_done_i;
    set_vec[mini_mcu_pkg::INTR_GPIO_LSB +: $bits(mini_mcu_pkg::gpio_t)] = rise;
    clr_vec = '0;
    if (wr && off_i == mini_mcu_pkg::REG_INTR_STATUS) begin
      clr_vec = wdata_i[$bits(mini_mcu_pkg::intr_t)-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      start_q  <= 1'b0;
      src_q    <= '0;
      dst_q    <= '0;
      len_q    <= '0;
      out_q    <= '0;
      oe_q     <= '0;
      sync1_q  <= '0;
      sync2_q  <= '0;
      prev_q   <= '0;
      status_q <= '0;
      enable_q <= '0;
    end else begin
      start_q  <= len_wr;
      sync1_q  <= gpio_i;
      sync2_q  <= sync1_q;
      prev_q   <= sync2_q;
      // Set events take priority over a clear
      status_q <= (status_q & ~clr_vec) | set_vec;
      if (len_wr) begin
        len_q <= wdata_i;
      end
      if (wr) begin
        case (off_i)
          mini_mcu_pkg::REG_DMA_SRC:     src_q    <= wdata_i;
          mini_mcu_pkg::REG_DMA_DST:     dst_q    <= wdata_i;
          mini_mcu_pkg::REG_GPIO_OUT:    out_q    <= wdata_i[7:0];
          mini_mcu_pkg::REG_GPIO_OE:     oe_q     <= wdata_i[7:0];
          mini_mcu_pkg::REG_INTR_ENABLE: enable_q <= wdata_i[15:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      case (off_i)
        mini_mcu_pkg::REG_DMA_SRC:     rdata_q <= src_q;
        mini_mcu_pkg::REG_DMA_DST:     rdata_q <= dst_q;
        mini_mcu_pkg::REG_DMA_LEN:     rdata_q <= len_q;
        mini_mcu_pkg::REG_DMA_STATUS:  rdata_q <= {31'b0, dma_busy_i};
        mini_mcu_pkg::REG_GPIO_OUT:    rdata_q <= {24'b0, out_q};
        mini_mcu_pkg::REG_GPIO_OE:     rdata_q <= {24'b0, oe_q};
        mini_mcu_pkg::REG_GPIO_IN:     rdata_q <= {24'b0, sync2_q};
        mini_mcu_pkg::REG_INTR_STATUS: rdata_q <= {16'b0, status_q};
        mini_mcu_pkg::REG_INTR_ENABLE: rdata_q <= {16'b0, enable_q};
        default:                       rdata_q <= '0;
      endcase
    end
  end

  assign rdata_o     = rdata_q;
  assign dma_start_o = start_q;
  assign dma_src_o   = src_q;
  assign dma_dst_o   = dst_q;
  assign dma_len_o   = len_q;
  assign gpio_o      = out_q;
  assign gpio_oe_o   = oe_q;
  assign intr_o      = |(status_q & enable_q);

endmodule

// ==== rtl/mini_mcu.sv ====
// mini_mcu top level
// Host port and DMA share the system bus to RAM and always-on peripherals
`timescale 1ns/1ps

module mini_mcu (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                host_req_i,
  input  logic                host_we_i,
  input  mini_mcu_pkg::addr_t host_addr_i,
  input  mini_mcu_pkg::data_t host_wdata_i,
  output logic                host_gnt_o,
  output logic                host_rvalid_o,
  output mini_mcu_pkg::data_t host_rdata_o,
  input  mini_mcu_pkg::gpio_t gpio_i,
  output mini_mcu_pkg::gpio_t gpio_o,
  output mini_mcu_pkg::gpio_t gpio_oe_o,
  output logic                intr_o
);

  // DMA master port
  logic                   dma_req, dma_we, dma_gnt, dma_rvalid;
  mini_mcu_pkg::addr_t    dma_addr;
  mini_mcu_pkg::data_t    dma_wdata, dma_rdata;

  // Slave ports
  logic                   ram_req, ram_we;
  mini_mcu_pkg::addr_t    ram_addr;
  mini_mcu_pkg::data_t    ram_wdata, ram_rdata;
  logic                   periph_req, periph_we;
  mini_mcu_pkg::reg_off_t periph_off;
  mini_mcu_pkg::data_t    periph_wdata, periph_rdata;

  // DMA channel control
  logic                   dma_start, dma_busy, dma_done;
  mini_mcu_pkg::addr_t    dma_src, dma_dst;
  mini_mcu_pkg::data_t    dma_len;

  bus_arbiter bus_arbiter_i (
    .clk_i, .arst_n_i,
    .host_req_i, .host_we_i, .host_addr_i, .host_wdata_i,
    .host_gnt_o, .host_rvalid_o, .host_rdata_o,
    .dma_req_i(dma_req), .dma_we_i(dma_we), .dma_addr_i(dma_addr), .dma_wdata_i(dma_wdata),
    .dma_gnt_o(dma_gnt), .dma_rvalid_o(dma_rvalid), .dma_rdata_o(dma_rdata),
    .ram_req_o(ram_req), .ram_we_o(ram_we), .ram_addr_o(ram_addr),
    .ram_wdata_o(ram_wdata), .ram_rdata_i(ram_rdata),
    .periph_req_o(periph_req), .periph_we_o(periph_we), .periph_off_o(periph_off),
    .periph_wdata_o(periph_wdata), .periph_rdata_i(periph_rdata)
  );

  ram_bank_array ram_bank_array_i (
    .clk_i, .req_i(ram_req), .we_i(ram_we), .addr_i(ram_addr),
    .wdata_i(ram_wdata), .rdata_o(ram_rdata)
  );

  dma_engine dma_engine_i (
    .clk_i, .arst_n_i,
    .start_i(dma_start), .src_i(dma_src), .dst_i(dma_dst), .len_i(dma_len),
    .busy_o(dma_busy), .done_o(dma_done),
    .bus_req_o(dma_req), .bus_we_o(dma_we), .bus_addr_o(dma_addr), .bus_wdata_o(dma_wdata),
    .bus_gnt_i(dma_gnt), .bus_rvalid_i(dma_rvalid), .bus_rdata_i(dma_rdata)
  );

  ao_peripherals ao_peripherals_i (
    .clk_i, .arst_n_i,
    .req_i(periph_req), .we_i(periph_we), .off_i(periph_off),
    .wdata_i(periph_wdata), .rdata_o(periph_rdata),
    .dma_start_o(dma_start), .dma_src_o(dma_src), .dma_dst_o(dma_dst), .dma_len_o(dma_len),
    .dma_busy_i(dma_busy), .dma_done_i(dma_done),
    .gpio_i, .gpio_o, .gpio_oe_o, .intr_o
  );

endmodule

// ==== tb/tb_mini_mcu.sv ====
// mini_mcu testbench
// Host bus traffic against a RAM model, GPIO, interrupts and a DMA copy
`timescale 1ns/1ps

module tb_mini_mcu;

  logic                clk;
  logic                arst_n;
  logic                host_req;
  logic                host_we;
  mini_mcu_pkg::addr_t host_addr;
  mini_mcu_pkg::data_t host_wdata;
  logic                host_gnt;
  logic                host_rvalid;
  mini_mcu_pkg::data_t host_rdata;
  mini_mcu_pkg::gpio_t gpio_in;
  mini_mcu_pkg::gpio_t gpio_out;
  mini_mcu_pkg::gpio_t gpio_oe;
  logic                intr;

  int                  check_errors;
  int                  timeouts;
  logic [31:0]         lfsr_q;
  logic                gnt_prev;
  logic                we_prev;
  mini_mcu_pkg::data_t rsp_q [$];
  mini_mcu_pkg::addr_t burst_q [$];
  mini_mcu_pkg::data_t ram_model [mini_mcu_pkg::NUM_BANKS * mini_mcu_pkg::BANK_WORDS];

  mini_mcu mini_mcu_i (
    .clk_i(clk), .arst_n_i(arst_n),
    .host_req_i(host_req), .host_we_i(host_we), .host_addr_i(host_addr),
    .host_wdata_i(host_wdata), .host_gnt_o(host_gnt), .host_rvalid_o(host_rvalid),
    .host_rdata_o(host_rdata),
    .gpio_i(gpio_in), .gpio_o(gpio_out), .gpio_oe_o(gpio_oe), .intr_o(intr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1
  function automatic mini_mcu_pkg::data_t rand_bits(int n);
    mini_mcu_pkg::data_t v;
    logic                fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_eq(string name, mini_mcu_pkg::data_t exp, mini_mcu_pkg::data_t act);
    assert (act === exp) else begin
      check_errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // One response per grant with read data collected in order
  always @(negedge clk) begin
    if (arst_n) begin
      check_eq("rvalid after grant", gnt_prev, host_rvalid);
      if (host_rvalid && !we_prev) begin
        rsp_q.push_back(host_rdata);
      end
    end
    gnt_prev = host_gnt;
    we_prev  = host_we;
  end

  task automatic host_issue(logic we, mini_mcu_pkg::addr_t addr, mini_mcu_pkg::data_t wdata);
    int waits;
    waits = 0;
    @(posedge clk);
    host_req   <= 1'b1;
    host_we    <= we;
    host_addr  <= addr;
    host_wdata <= wdata;
    @(negedge clk);
    while (!host_gnt && waits < 50) begin
      @(negedge clk);
      waits++;
    end
    if (!host_gnt) begin
      timeouts++;
      $display("Timeout: host request to %h was never granted", addr);
    end else begin
      assert (waits <= 1) else begin
        check_errors++;
        $display("CHECK FAILED grant latency: expected at most 1, actual %0d", waits);
      end
    end
  endtask

  task automatic host_idle();
    @(posedge clk);
    host_req <= 1'b0;
  endtask

  task automatic wait_responses(int n);
    int waits;
    waits = 0;
    while (rsp_q.size() < n && waits < 50) begin
      @(posedge clk);
      waits++;
    end
    if (rsp_q.size() < n) begin
      timeouts++;
      $display("Timeout: only %0d of %0d read responses arrived", rsp_q.size(), n);
    end
  endtask

  task automatic host_write(mini_mcu_pkg::addr_t addr, mini_mcu_pkg::data_t wdata);
    host_issue(1'b1, addr, wdata);
    host_idle();
    @(negedge clk);
  endtask

  task automatic host_read(mini_mcu_pkg::addr_t addr, output mini_mcu_pkg::data_t rdata);
    host_issue(1'b0, addr, '0);
    host_idle();
    wait_responses(1);
    rdata = (rsp_q.size() > 0) ? rsp_q.pop_front() : 'x;
  endtask

  task automatic read_check(string name, mini_mcu_pkg::addr_t addr, mini_mcu_pkg::data_t exp);
    mini_mcu_pkg::data_t d;
    host_read(addr, d);
    check_eq(name, exp, d);
  endtask

  // Back-to-back reads of every queued address against the model
  task automatic verify_burst(string name);
    foreach (burst_q[i]) begin
      host_issue(1'b0, burst_q[i], '0);
    end
    host_idle();
    wait_responses(burst_q.size());
    foreach (burst_q[i]) begin
      if (rsp_q.size() > 0) begin
        check_eq(name, ram_model[burst_q[i] >> 2], rsp_q.pop_front());
      end
    end
  endtask

  task automatic ram_burst(string name);
    mini_mcu_pkg::data_t d;
    foreach (burst_q[i]) begin
      d = rand_bits(32);
      ram_model[burst_q[i] >> 2] = d;
      host_issue(1'b1, burst_q[i], d);
    end
    host_idle();
    verify_burst(name);
  endtask

  initial begin
    mini_mcu_pkg::data_t d;
    mini_mcu_pkg::addr_t pb;
    int                  pin;
    int                  other;
    int                  waits;
    check_errors = 0;
    timeouts     = 0;
    lfsr_q       = 32'h1e43e41e;
    pb           = mini_mcu_pkg::PERIPH_BASE;
    arst_n       = 1'b0;
    host_req     = 1'b0;
    host_we      = 1'b0;
    host_addr    = '0;
    host_wdata   = '0;
    gpio_in      = '0;
    @(posedge clk);
    repeat (5) begin
      @(negedge clk);
      check_eq("reset state", '0, {host_gnt, host_rvalid, gpio_out, gpio_oe, intr});
    end
    @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_eq("after reset", '0, {host_gnt, host_rvalid, gpio_out, gpio_oe, intr});

    // First and top word of both banks
    burst_q = {32'h000, 32'h3FC, 32'h400, 32'h7FC};
    for (int i = 0; i < 12; i++) begin
      burst_q.push_back(rand_bits(9) << 2);
    end
    ram_burst("ram readback");
    read_check("unmapped read", 32'h0000_0800, mini_mcu_pkg::UNMAPPED_RDATA);

    d = rand_bits(8);
    host_write(pb + mini_mcu_pkg::REG_GPIO_OUT, d);
    check_eq("gpio_o", d, gpio_out);
    read_check("gpio out readback", pb + mini_mcu_pkg::REG_GPIO_OUT, d);
    d = rand_bits(8);
    host_write(pb + mini_mcu_pkg::REG_GPIO_OE, d);
    check_eq("gpio_oe_o", d, gpio_oe);
    read_check("gpio oe readback", pb + mini_mcu_pkg::REG_GPIO_OE, d);
    d = rand_bits(8);
    @(posedge clk);
    gpio_in <= d;
    repeat (3) @(posedge clk);
    read_check("gpio input", pb + mini_mcu_pkg::REG_GPIO_IN, d);

    // Pins low and status clean before the edge tests
    @(posedge clk);
    gpio_in <= '0;
    repeat (3) @(posedge clk);
    host_write(pb + mini_mcu_pkg::REG_INTR_STATUS, 32'hFFFF);
    pin   = rand_bits(3);
    other = (pin + 1) % 8;
    host_write(pb + mini_mcu_pkg::REG_INTR_ENABLE, 1 << (mini_mcu_pkg::INTR_GPIO_LSB + pin));
    @(posedge clk);
    gpio_in <= mini_mcu_pkg::gpio_t'(1 << pin);
    waits = 0;
    @(negedge clk);
    while (!intr && waits < 10) begin
      @(negedge clk);
      waits++;
    end
    if (!intr) begin
      timeouts++;
      $display("Timeout: GPIO pin %0d edge raised no interrupt", pin);
    end
    read_check("gpio status", pb + mini_mcu_pkg::REG_INTR_STATUS,
               1 << (mini_mcu_pkg::INTR_GPIO_LSB + pin));
    host_write(pb + mini_mcu_pkg::REG_INTR_STATUS, 1 << (mini_mcu_pkg::INTR_GPIO_LSB + pin));
    check_eq("intr after clear", 0, intr);
    read_check("status after clear", pb + mini_mcu_pkg::REG_INTR_STATUS, 0);
    @(posedge clk);
    gpio_in <= mini_mcu_pkg::gpio_t'((1 << pin) | (1 << other));
    repeat (5) begin
      @(negedge clk);
      check_eq("disabled pin intr", 0, intr);
    end
    read_check("disabled pin status", pb + mini_mcu_pkg::REG_INTR_STATUS,
               1 << (mini_mcu_pkg::INTR_GPIO_LSB + other));
    host_write(pb + mini_mcu_pkg::REG_INTR_STATUS, 32'hFFFF);

    // Source in bank 0 with destination and two guard words in bank 1
    burst_q.delete();
    for (int i = 0; i < 16; i++) begin
      burst_q.push_back(32'h100 + 4 * i);
    end
    for (int i = 0; i < 18; i++) begin
      burst_q.push_back(32'h500 + 4 * i);
    end
    ram_burst("dma preload");
    host_write(pb + mini_mcu_pkg::REG_INTR_ENABLE, 1 << mini_mcu_pkg::INTR_DMA_DONE_BIT);
    host_write(pb + mini_mcu_pkg::REG_DMA_SRC, 32'h100);
    host_write(pb + mini_mcu_pkg::REG_DMA_DST, 32'h500);
    host_write(pb + mini_mcu_pkg::REG_DMA_LEN, 16);
    read_check("dma busy", pb + mini_mcu_pkg::REG_DMA_STATUS, 1);
    host_write(pb + mini_mcu_pkg::REG_DMA_LEN, 3);
    waits = 0;
    while (!intr && waits < 200) begin
      host_read(pb + mini_mcu_pkg::REG_DMA_STATUS, d);
      @(negedge clk);
      waits++;
    end
    if (!intr) begin
      timeouts++;
      $display("Timeout: DMA copy never raised its done interrupt");
    end
    for (int i = 0; i < 16; i++) begin
      ram_model[(32'h500 >> 2) + i] = ram_model[(32'h100 >> 2) + i];
    end
    read_check("dma idle", pb + mini_mcu_pkg::REG_DMA_STATUS, 0);
    read_check("dma length kept", pb + mini_mcu_pkg::REG_DMA_LEN, 16);
    read_check("dma done status", pb + mini_mcu_pkg::REG_INTR_STATUS,
               1 << mini_mcu_pkg::INTR_DMA_DONE_BIT);
    verify_burst("dma copy");

    $display("Failed checks: %0d, timeouts: %0d", check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== mini_mcu.f ====
rtl/mini_mcu_pkg.sv
rtl/bus_arbiter.sv
rtl/ram_bank_array.sv
rtl/dma_engine.sv
rtl/ao_peripherals.sv
rtl/mini_mcu.sv
tb/tb_mini_mcu.sv

// ==== Bender.yml ====
package:
  name: mini_mcu

sources:
  - rtl/mini_mcu_pkg.sv
  - rtl/bus_arbiter.sv
  - rtl/ram_bank_array.sv
  - rtl/dma_engine.sv
  - rtl/ao_peripherals.sv
  - rtl/mini_mcu.sv
  - target: test
    files:
      - tb/tb_mini_mcu.sv
